//--- include/dm_config.svh
/*
 * Widths and sizes shared by the debug and memory blocks.
 * Host words are half a data word, since a 32-bit write arrives as two halves.
 * Addresses are word addresses and there are no byte selects.
 * DM_MEM_WORDS sets the RAM depth; anything at or above it answers SLVERR.
 */

`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// Host link word
`define DM_HOST_WIDTH 16

// Word address on Wishbone and AXI
`define DM_ADDR_WIDTH 16

// Memory data word
`define DM_DATA_WIDTH 32

// Implemented RAM depth in words
`define DM_MEM_WORDS 1024

`endif

//--- verilog/dbg_pkg.sv
/*
 * Host protocol types for the debug controller.
 * The opcode sits in bits 15 to 12 of the first frame word.
 * Opcode values not listed here are legal on the wire and answered as bad commands.
 */

package dbg_pkg;

   // Frame opcodes
   typedef enum logic [3:0] {
      CMD_NOP         = 4'd0,
      CMD_WRITE       = 4'd1,
      CMD_READ        = 4'd2,
      CMD_CPU_RST_SET = 4'd3,
      CMD_CPU_RST_CLR = 4'd4
   } dbg_cmd_e;

   // Reply status in the low nibble of the status word
   typedef enum logic [3:0] {
      ST_OK      = 4'd1,
      ST_BAD_CMD = 4'd2,
      ST_BUS_ERR = 4'd3
   } dbg_status_e;

   typedef enum logic [1:0] {
      IDLE,
      BUS,
      REPLY
   } dbg_state_e;

endpackage

//--- verilog/mem_pkg.sv
/*
 * Bus-side types for the Wishbone to AXI path.
 * Only OKAY and SLVERR are produced by the RAM model.
 */

package mem_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   // Bridge sequencing for one transaction at a time
   typedef enum logic [2:0] {
      B_IDLE,
      B_WADDR,
      B_WRESP,
      B_RADDR,
      B_RDATA,
      B_DONE
   } bridge_state_e;

endpackage

//--- verilog/dbg_word_rx.sv
/*
 * Collects host words into a command frame.
 * There is no ready signal and the host must wait for a reply before the next frame.
 * A write is four words, a read two, every other opcode one.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dbg_word_rx import dbg_pkg::*; (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic [`DM_HOST_WIDTH-1:0] host_in_data_i,
   input  logic                      host_in_valid_i,
   output logic                      cmd_valid_o,
   output dbg_cmd_e                  cmd_op_o,
   output logic [`DM_ADDR_WIDTH-1:0] cmd_addr_o,
   output logic [`DM_DATA_WIDTH-1:0] cmd_wdata_o
);

   // Words still expected in the current frame
   logic [1:0] rem;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         rem         <= 2'd0;
         cmd_valid_o <= 1'b0;
      end else begin
         cmd_valid_o <= 1'b0;
         if (host_in_valid_i) begin
            if (rem == 2'd0) begin
               case (dbg_cmd_e'(host_in_data_i[15:12]))
                  CMD_WRITE: rem <= 2'd3;
                  CMD_READ:  rem <= 2'd1;
                  default:   cmd_valid_o <= 1'b1;
               endcase
            end else begin
               rem <= rem - 2'd1;
               if (rem == 2'd1) begin
                  cmd_valid_o <= 1'b1;
               end
            end
         end
      end
   end

   // Frame field slot follows the remaining count
   always_ff @(posedge sys_clk_i) begin
      if (host_in_valid_i) begin
         case (rem)
            2'd0: cmd_op_o <= dbg_cmd_e'(host_in_data_i[15:12]);
            2'd3: cmd_addr_o <= host_in_data_i;
            2'd2: cmd_wdata_o[`DM_HOST_WIDTH-1:0] <= host_in_data_i;
            default: begin
               // Last word is the address for a read, the high half for a write
               if (cmd_op_o == CMD_READ) begin
                  cmd_addr_o <= host_in_data_i;
               end else begin
                  cmd_wdata_o[`DM_DATA_WIDTH-1:`DM_HOST_WIDTH] <= host_in_data_i;
               end
            end
         endcase
      end
   end

   a_single_pulse: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      cmd_valid_o |=> !cmd_valid_o);

endmodule

//--- verilog/dbg_ctrl.sv
/*
 * Debug command controller.
 * Memory commands become one Wishbone single cycle; cyc stays up until ack or err.
 * The CPU reset comes out of system reset asserted and only the host releases it.
 * A new command while a reply is pending breaks the host protocol.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dbg_ctrl import dbg_pkg::*; (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic                      cmd_valid_i,
   input  dbg_cmd_e                  cmd_op_i,
   input  logic [`DM_ADDR_WIDTH-1:0] cmd_addr_i,
   input  logic [`DM_DATA_WIDTH-1:0] cmd_wdata_i,
   output logic                      wb_cyc_o,
   output logic                      wb_we_o,
   output logic [`DM_ADDR_WIDTH-1:0] wb_adr_o,
   output logic [`DM_DATA_WIDTH-1:0] wb_dat_o,
   input  logic                      wb_ack_i,
   input  logic                      wb_err_i,
   input  logic [`DM_DATA_WIDTH-1:0] wb_dat_i,
   output logic                      rep_valid_o,
   output logic [1:0]                rep_len_o,
   output logic [`DM_HOST_WIDTH-1:0] rep_status_word_o,
   output logic [`DM_DATA_WIDTH-1:0] rep_data_o,
   output logic                      cpu_rst_o
);

   dbg_state_e  state;
   dbg_cmd_e    op_q;
   dbg_status_e status_q;
   logic [1:0]  len_q;
   logic [`DM_DATA_WIDTH-1:0] data_q;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         state     <= IDLE;
         wb_cyc_o  <= 1'b0;
         cpu_rst_o <= 1'b1;
      end else begin
         case (state)
            IDLE: begin
               if (cmd_valid_i) begin
                  case (cmd_op_i)
                     CMD_WRITE, CMD_READ: begin
                        wb_cyc_o <= 1'b1;
                        state    <= BUS;
                     end
                     CMD_CPU_RST_SET: begin
                        cpu_rst_o <= 1'b1;
                        state     <= REPLY;
                     end
                     CMD_CPU_RST_CLR: begin
                        cpu_rst_o <= 1'b0;
                        state     <= REPLY;
                     end
                     default: state <= REPLY;
                  endcase
               end
            end
            BUS: begin
               if (wb_ack_i || wb_err_i) begin
                  wb_cyc_o <= 1'b0;
                  state    <= REPLY;
               end
            end
            // Reply is presented for exactly one cycle
            default: state <= IDLE;
         endcase
      end
   end

   // Bus request and reply contents
   always_ff @(posedge sys_clk_i) begin
      if (state == IDLE && cmd_valid_i) begin
         op_q     <= cmd_op_i;
         wb_we_o  <= (cmd_op_i == CMD_WRITE);
         wb_adr_o <= cmd_addr_i;
         wb_dat_o <= cmd_wdata_i;
         len_q    <= 2'd1;
         case (cmd_op_i)
            CMD_NOP, CMD_CPU_RST_SET, CMD_CPU_RST_CLR: status_q <= ST_OK;
            default: status_q <= ST_BAD_CMD;
         endcase
      end else if (state == BUS && wb_ack_i) begin
         status_q <= ST_OK;
         data_q   <= wb_dat_i;
         len_q    <= wb_we_o ? 2'd1 : 2'd3;
      end else if (state == BUS && wb_err_i) begin
         status_q <= ST_BUS_ERR;
      end
   end

   assign rep_valid_o       = (state == REPLY);
   assign rep_len_o         = len_q;
   assign rep_data_o        = data_q;
   assign rep_status_word_o = {op_q, {(`DM_HOST_WIDTH-8){1'b0}}, status_q};

   a_cyc_in_bus: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      wb_cyc_o |-> state == BUS);

   // Host sent a frame before the previous reply went out
   a_cmd_in_idle: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      cmd_valid_i |-> state == IDLE);

endmodule

//--- verilog/wb2axi.sv
/*
 * Wishbone classic single cycle to AXI single beat.
 * cyc alone qualifies a full-word access; no stb, sel, cti or bte.
 * AW and W are raised together; any non-OKAY response becomes err.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module wb2axi import mem_pkg::*; (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic                      wb_cyc_i,
   input  logic                      wb_we_i,
   input  logic [`DM_ADDR_WIDTH-1:0] wb_adr_i,
   input  logic [`DM_DATA_WIDTH-1:0] wb_dat_i,
   output logic                      wb_ack_o,
   output logic                      wb_err_o,
   output logic [`DM_DATA_WIDTH-1:0] wb_dat_o,
   output logic [`DM_ADDR_WIDTH-1:0] axi_awaddr_o,
   output logic                      axi_awvalid_o,
   input  logic                      axi_awready_i,
   output logic [`DM_DATA_WIDTH-1:0] axi_wdata_o,
   output logic                      axi_wvalid_o,
   input  logic                      axi_wready_i,
   input  axi_resp_e                 axi_bresp_i,
   input  logic                      axi_bvalid_i,
   output logic                      axi_bready_o,
   output logic [`DM_ADDR_WIDTH-1:0] axi_araddr_o,
   output logic                      axi_arvalid_o,
   input  logic                      axi_arready_i,
   input  logic [`DM_DATA_WIDTH-1:0] axi_rdata_i,
   input  axi_resp_e                 axi_rresp_i,
   input  logic                      axi_rvalid_i,
   output logic                      axi_rready_o
);

   bridge_state_e state;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         state         <= B_IDLE;
         axi_awvalid_o <= 1'b0;
         axi_wvalid_o  <= 1'b0;
         axi_arvalid_o <= 1'b0;
         wb_ack_o      <= 1'b0;
         wb_err_o      <= 1'b0;
      end else begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         case (state)
            B_IDLE: begin
               if (wb_cyc_i && wb_we_i) begin
                  axi_awvalid_o <= 1'b1;
                  axi_wvalid_o  <= 1'b1;
                  state         <= B_WADDR;
               end else if (wb_cyc_i) begin
                  axi_arvalid_o <= 1'b1;
                  state         <= B_RADDR;
               end
            end
            B_WADDR: begin
               // AW and W may be taken on different cycles
               if (axi_awready_i) axi_awvalid_o <= 1'b0;
               if (axi_wready_i) axi_wvalid_o <= 1'b0;
               if ((!axi_awvalid_o || axi_awready_i) && (!axi_wvalid_o || axi_wready_i)) begin
                  state <= B_WRESP;
               end
            end
            B_WRESP: begin
               if (axi_bvalid_i) begin
                  wb_ack_o <= (axi_bresp_i == OKAY);
                  wb_err_o <= (axi_bresp_i != OKAY);
                  state    <= B_DONE;
               end
            end
            B_RADDR: begin
               if (axi_arready_i) begin
                  axi_arvalid_o <= 1'b0;
                  state         <= B_RDATA;
               end
            end
            B_RDATA: begin
               if (axi_rvalid_i) begin
                  wb_ack_o <= (axi_rresp_i == OKAY);
                  wb_err_o <= (axi_rresp_i != OKAY);
                  state    <= B_DONE;
               end
            end
            // cyc drops on this edge, so idle again
            default: state <= B_IDLE;
         endcase
      end
   end

   // Address, write data and read data
   always_ff @(posedge sys_clk_i) begin
      if (state == B_IDLE && wb_cyc_i) begin
         axi_awaddr_o <= wb_adr_i;
         axi_araddr_o <= wb_adr_i;
         axi_wdata_o  <= wb_dat_i;
      end
      if (state == B_RDATA && axi_rvalid_i) begin
         wb_dat_o <= axi_rdata_i;
      end
   end

   assign axi_bready_o = (state == B_WRESP);
   assign axi_rready_o = (state == B_RDATA);

   a_ack_err_excl: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      !(wb_ack_o && wb_err_o));

endmodule

//--- verilog/axi_ram.sv
/*
 * Single-beat AXI slave RAM in place of the DDR controller.
 * One outstanding transaction; the ready signals drop while a response waits.
 * Accesses at or above DM_MEM_WORDS get SLVERR and do not touch the array.
 * The array has no reset and reads back undefined until written.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module axi_ram import mem_pkg::*; (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic [`DM_ADDR_WIDTH-1:0] axi_awaddr_i,
   input  logic                      axi_awvalid_i,
   output logic                      axi_awready_o,
   input  logic [`DM_DATA_WIDTH-1:0] axi_wdata_i,
   input  logic                      axi_wvalid_i,
   output logic                      axi_wready_o,
   output axi_resp_e                 axi_bresp_o,
   output logic                      axi_bvalid_o,
   input  logic                      axi_bready_i,
   input  logic [`DM_ADDR_WIDTH-1:0] axi_araddr_i,
   input  logic                      axi_arvalid_i,
   output logic                      axi_arready_o,
   output logic [`DM_DATA_WIDTH-1:0] axi_rdata_o,
   output axi_resp_e                 axi_rresp_o,
   output logic                      axi_rvalid_o,
   input  logic                      axi_rready_i
);

   localparam int IDX_W = $clog2(`DM_MEM_WORDS);

   logic [`DM_DATA_WIDTH-1:0] mem [`DM_MEM_WORDS];

   logic busy, aw_have, w_have, aw_fire, w_fire, ar_fire, do_write;
   logic [`DM_ADDR_WIDTH-1:0] aw_q, waddr;
   logic [`DM_DATA_WIDTH-1:0] w_q, wdata;

   assign busy          = axi_bvalid_o || axi_rvalid_o;
   assign axi_awready_o = !busy && !aw_have;
   assign axi_wready_o  = !busy && !w_have;
   assign axi_arready_o = !busy;
   assign aw_fire  = axi_awvalid_i && axi_awready_o;
   assign w_fire   = axi_wvalid_i && axi_wready_o;
   assign ar_fire  = axi_arvalid_i && axi_arready_o;
   assign do_write = (aw_have || aw_fire) && (w_have || w_fire);

   // Use the held beat if it arrived earlier
   assign waddr = aw_have ? aw_q : axi_awaddr_i;
   assign wdata = w_have ? w_q : axi_wdata_i;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         aw_have      <= 1'b0;
         w_have       <= 1'b0;
         axi_bvalid_o <= 1'b0;
         axi_rvalid_o <= 1'b0;
      end else begin
         aw_have <= (aw_have || aw_fire) && !do_write;
         w_have  <= (w_have || w_fire) && !do_write;
         if (do_write) begin
            axi_bvalid_o <= 1'b1;
         end else if (axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
         end
         if (ar_fire && !do_write) begin
            axi_rvalid_o <= 1'b1;
         end else if (axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (aw_fire) aw_q <= axi_awaddr_i;
      if (w_fire) w_q <= axi_wdata_i;
      if (do_write) begin
         axi_bresp_o <= (waddr < `DM_MEM_WORDS) ? OKAY : SLVERR;
         if (waddr < `DM_MEM_WORDS) mem[waddr[IDX_W-1:0]] <= wdata;
      end
      if (ar_fire) begin
         axi_rresp_o <= (axi_araddr_i < `DM_MEM_WORDS) ? OKAY : SLVERR;
         axi_rdata_o <= mem[axi_araddr_i[IDX_W-1:0]];
      end
   end

   a_bvalid_hold: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
      axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o);

endmodule

//--- verilog/dbg_word_tx.sv
/*
 * Sends a one- or three-word reply to the host on back-to-back cycles.
 * The host has no back-pressure and must take every word.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dbg_word_tx (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic                      rep_valid_i,
   input  logic [1:0]                rep_len_i,
   input  logic [`DM_HOST_WIDTH-1:0] rep_status_word_i,
   input  logic [`DM_DATA_WIDTH-1:0] rep_data_i,
   output logic [`DM_HOST_WIDTH-1:0] host_out_data_o,
   output logic                      host_out_valid_o
);

   logic [`DM_HOST_WIDTH-1:0] sh [3];
   logic [1:0] cnt;

   always_ff @(posedge sys_clk_i) begin
      if (!rst_n_i) begin
         cnt <= 2'd0;
      end else if (rep_valid_i) begin
         cnt <= rep_len_i;
      end else if (cnt != 2'd0) begin
         cnt <= cnt - 2'd1;
      end
   end

   // Status word first, then low and high data halves
   always_ff @(posedge sys_clk_i) begin
      if (rep_valid_i) begin
         sh[0] <= rep_status_word_i;
         sh[1] <= rep_data_i[`DM_HOST_WIDTH-1:0];
         sh[2] <= rep_data_i[`DM_DATA_WIDTH-1:`DM_HOST_WIDTH];
      end else begin
         sh[0] <= sh[1];
         sh[1] <= sh[2];
      end
   end

   assign host_out_data_o  = sh[0];
   assign host_out_valid_o = (cnt != 2'd0);

endmodule

//--- verilog/dm_sys_top.sv
/*
 * Debug and memory subsystem top level.
 * Host words arrive on a plain strobe; one command is in flight at a time.
 * cpu_rst_o is high after reset until the host clears it.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module dm_sys_top import dbg_pkg::*, mem_pkg::*; (
   input  logic                      sys_clk_i,
   input  logic                      rst_n_i,
   input  logic [`DM_HOST_WIDTH-1:0] host_in_data_i,
   input  logic                      host_in_valid_i,
   output logic [`DM_HOST_WIDTH-1:0] host_out_data_o,
   output logic                      host_out_valid_o,
   output logic                      cpu_rst_o
);

   logic cmd_valid, rep_valid;
   dbg_cmd_e cmd_op;
   logic [`DM_ADDR_WIDTH-1:0] cmd_addr, wb_adr, awaddr, araddr;
   logic [`DM_DATA_WIDTH-1:0] cmd_wdata, wb_dat_w, wb_dat_r, wdata, rdata, rep_data;
   logic wb_cyc, wb_we, wb_ack, wb_err;
   logic [1:0] rep_len;
   logic [`DM_HOST_WIDTH-1:0] rep_status_word;

   // AXI handshakes between bridge and RAM
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   axi_resp_e bresp, rresp;

   dbg_word_rx u_rx (
      .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
      .host_in_data_i(host_in_data_i), .host_in_valid_i(host_in_valid_i),
      .cmd_valid_o(cmd_valid), .cmd_op_o(cmd_op),
      .cmd_addr_o(cmd_addr), .cmd_wdata_o(cmd_wdata));

   dbg_ctrl u_ctrl (
      .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
      .cmd_valid_i(cmd_valid), .cmd_op_i(cmd_op),
      .cmd_addr_i(cmd_addr), .cmd_wdata_i(cmd_wdata),
      .wb_cyc_o(wb_cyc), .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w),
      .wb_ack_i(wb_ack), .wb_err_i(wb_err), .wb_dat_i(wb_dat_r),
      .rep_valid_o(rep_valid), .rep_len_o(rep_len),
      .rep_status_word_o(rep_status_word), .rep_data_o(rep_data),
      .cpu_rst_o(cpu_rst_o));

   wb2axi u_wb2axi (
      .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
      .wb_cyc_i(wb_cyc), .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .wb_ack_o(wb_ack), .wb_err_o(wb_err), .wb_dat_o(wb_dat_r),
      .axi_awaddr_o(awaddr), .axi_awvalid_o(awvalid), .axi_awready_i(awready),
      .axi_wdata_o(wdata), .axi_wvalid_o(wvalid), .axi_wready_i(wready),
      .axi_bresp_i(bresp), .axi_bvalid_i(bvalid), .axi_bready_o(bready),
      .axi_araddr_o(araddr), .axi_arvalid_o(arvalid), .axi_arready_i(arready),
      .axi_rdata_i(rdata), .axi_rresp_i(rresp), .axi_rvalid_i(rvalid),
      .axi_rready_o(rready));

   axi_ram u_ram (
      .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
      .axi_awaddr_i(awaddr), .axi_awvalid_i(awvalid), .axi_awready_o(awready),
      .axi_wdata_i(wdata), .axi_wvalid_i(wvalid), .axi_wready_o(wready),
      .axi_bresp_o(bresp), .axi_bvalid_o(bvalid), .axi_bready_i(bready),
      .axi_araddr_i(araddr), .axi_arvalid_i(arvalid), .axi_arready_o(arready),
      .axi_rdata_o(rdata), .axi_rresp_o(rresp), .axi_rvalid_o(rvalid),
      .axi_rready_i(rready));

   dbg_word_tx u_tx (
      .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
      .rep_valid_i(rep_valid), .rep_len_i(rep_len),
      .rep_status_word_i(rep_status_word), .rep_data_i(rep_data),
      .host_out_data_o(host_out_data_o), .host_out_valid_o(host_out_valid_o));

endmodule

//--- testbench/tb_dm_sys.sv
/*
 * Testbench for the debug and memory subsystem.
 * One command is in flight at a time; the next frame goes out only after
 * the whole reply has been collected from the host output.
 * RAM contents are unknown after reset, so only written addresses are read back.
 */
`timescale 1ns/10ps
`include "dm_config.svh"

module tb_dm_sys import dbg_pkg::*; ();

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_WRITES   = 20;
   // Reset commands, writes, reads, error path and opcode checks
   localparam int NUM_CMDS     = 2 + 2 * NUM_WRITES + 3 + 2;
   localparam int WATCHDOG_NS  = (NUM_CMDS * 200 + RESET_CYCLES) * CLK_PERIOD;

   logic                      sys_clk = 1'b0;
   logic                      rst_n;
   logic [`DM_HOST_WIDTH-1:0] host_in_data;
   logic                      host_in_valid;
   logic [`DM_HOST_WIDTH-1:0] host_out_data;
   logic                      host_out_valid;
   logic                      cpu_rst;

   logic [`DM_HOST_WIDTH-1:0] rep_q [$];
   logic [`DM_DATA_WIDTH-1:0] shadow [logic [`DM_ADDR_WIDTH-1:0]];
   logic [`DM_ADDR_WIDTH-1:0] addrs [NUM_WRITES];
   logic [`DM_ADDR_WIDTH-1:0] victim;
   logic [`DM_ADDR_WIDTH-1:0] bad_addr;
   logic [`DM_DATA_WIDTH-1:0] wdata;
   logic [3:0]                cur_op = 4'h0;
   logic [3:0]                bad_op;
   logic                      cmd_started = 1'b0;
   logic                      exp_cpu_rst = 1'b1;
   int                        mismatch_cnt = 0;
   int                        fail_cnt = 0;

   dm_sys_top uut (
      .sys_clk_i(sys_clk), .rst_n_i(rst_n),
      .host_in_data_i(host_in_data), .host_in_valid_i(host_in_valid),
      .host_out_data_o(host_out_data), .host_out_valid_o(host_out_valid),
      .cpu_rst_o(cpu_rst));

   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   // Reply monitor
   always @(posedge sys_clk) begin
      if (rst_n && host_out_valid) begin
         rep_q.push_back(host_out_data);
      end
   end

   a_quiet_before_cmd: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !cmd_started |-> !host_out_valid)
      else begin
         $display("mismatch at %0t: host_out_valid_o got 1 expected 0", $time);
         mismatch_cnt++;
      end

   a_cpu_rst_after_reset: assert property (@(posedge sys_clk) $rose(rst_n) |-> cpu_rst)
      else begin
         $display("mismatch at %0t: cpu_rst_o got 0 expected 1", $time);
         mismatch_cnt++;
      end

   // Only the two reset commands may move the tile reset
   a_cpu_rst_by_cmd: assert property (@(posedge sys_clk) disable iff (!rst_n)
      !$stable(cpu_rst) |-> (cur_op == CMD_CPU_RST_SET || cur_op == CMD_CPU_RST_CLR))
      else begin
         $display("%0t: cpu_rst_o changed during opcode %h", $time, cur_op);
         fail_cnt++;
      end

   function automatic logic [`DM_HOST_WIDTH-1:0] status_word(input logic [3:0] op,
                                                             input logic [3:0] st);
      return {op, 8'h00, st};
   endfunction

   task automatic send_word(input logic [`DM_HOST_WIDTH-1:0] w);
      @(posedge sys_clk);
      #1;
      host_in_data  = w;
      host_in_valid = 1'b1;
   endtask

   // Sends one frame, then checks the reply words and the tile reset level
   task automatic do_cmd(input logic [3:0] op, input logic [`DM_ADDR_WIDTH-1:0] addr,
                         input logic [`DM_DATA_WIDTH-1:0] data, input int len,
                         input logic [15:0] w0, input logic [15:0] w1,
                         input logic [15:0] w2);
      logic [`DM_HOST_WIDTH-1:0] exp_w [3];
      logic [`DM_HOST_WIDTH-1:0] got;
      exp_w[0]    = w0;
      exp_w[1]    = w1;
      exp_w[2]    = w2;
      cur_op      = op;
      cmd_started = 1'b1;
      send_word({op, 12'h000});
      if (op == CMD_WRITE) begin
         send_word(addr);
         send_word(data[15:0]);
         send_word(data[31:16]);
      end else if (op == CMD_READ) begin
         send_word(addr);
      end
      @(posedge sys_clk);
      #1;
      host_in_valid = 1'b0;
      host_in_data  = '0;
      while (rep_q.size() < len) @(negedge sys_clk);
      for (int i = 0; i < len; i++) begin
         got = rep_q.pop_front();
         assert (got == exp_w[i])
            else begin
               $display("mismatch at %0t: host_out_data_o word %0d got %h expected %h",
                        $time, i, got, exp_w[i]);
               mismatch_cnt++;
            end
      end
      assert (cpu_rst == exp_cpu_rst)
         else begin
            $display("mismatch at %0t: cpu_rst_o got %b expected %b",
                     $time, cpu_rst, exp_cpu_rst);
            mismatch_cnt++;
         end
      // Words arrive back to back, so one more cycle shows any extra word
      @(negedge sys_clk);
      assert (rep_q.size() == 0)
         else begin
            $display("%0t: reply to opcode %h had more words than expected", $time, op);
            fail_cnt++;
            rep_q.delete();
         end
   endtask

   initial begin
      void'($urandom(32'h43d6_79c5));
      rst_n         = 1'b0;
      host_in_data  = '0;
      host_in_valid = 1'b0;
      repeat (RESET_CYCLES) @(posedge sys_clk);
      #1;
      rst_n = 1'b1;
      repeat (5) @(posedge sys_clk);

      // Tile reset release and reassert
      exp_cpu_rst = 1'b0;
      do_cmd(CMD_CPU_RST_CLR, '0, '0, 1, status_word(CMD_CPU_RST_CLR, ST_OK), '0, '0);
      exp_cpu_rst = 1'b1;
      do_cmd(CMD_CPU_RST_SET, '0, '0, 1, status_word(CMD_CPU_RST_SET, ST_OK), '0, '0);

      // Random writes, then read back
      for (int i = 0; i < NUM_WRITES; i++) begin
         addrs[i]         = 16'($urandom_range(`DM_MEM_WORDS - 1, 0));
         wdata            = $urandom();
         shadow[addrs[i]] = wdata;
         do_cmd(CMD_WRITE, addrs[i], wdata, 1, status_word(CMD_WRITE, ST_OK), '0, '0);
      end
      for (int i = 0; i < NUM_WRITES; i++) begin
         do_cmd(CMD_READ, addrs[i], '0, 3, status_word(CMD_READ, ST_OK),
                shadow[addrs[i]][15:0], shadow[addrs[i]][31:16]);
      end

      // Out of range; the bad write aliases the victim in the low address bits
      victim   = addrs[0];
      bad_addr = victim + 16'(`DM_MEM_WORDS * (1 + $urandom_range(62, 0)));
      do_cmd(CMD_WRITE, bad_addr, ~shadow[victim], 1,
             status_word(CMD_WRITE, ST_BUS_ERR), '0, '0);
      bad_addr = 16'($urandom_range(16'hffff, `DM_MEM_WORDS));
      do_cmd(CMD_READ, bad_addr, '0, 1, status_word(CMD_READ, ST_BUS_ERR), '0, '0);
      do_cmd(CMD_READ, victim, '0, 3, status_word(CMD_READ, ST_OK),
             shadow[victim][15:0], shadow[victim][31:16]);

      // Unknown opcode and NOP
      bad_op = 4'($urandom_range(15, 5));
      do_cmd(bad_op, '0, '0, 1, status_word(bad_op, ST_BAD_CMD), '0, '0);
      do_cmd(CMD_NOP, '0, '0, 1, status_word(CMD_NOP, ST_OK), '0, '0);

      repeat (4) @(posedge sys_clk);
      $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      fail_cnt++;
      $display("%0t: watchdog expired before all replies arrived", $time);
      $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      $display("Errors found");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+include
verilog/dbg_pkg.sv
verilog/mem_pkg.sv
verilog/dbg_word_rx.sv
verilog/dbg_ctrl.sv
verilog/wb2axi.sv
verilog/axi_ram.sv
verilog/dbg_word_tx.sv
verilog/dm_sys_top.sv
testbench/tb_dm_sys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_dm_sys -o tb_dm_sys

out=$(./obj_dir/tb_dm_sys)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
   exit 0
else
   exit 1
fi
